// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_decode_stage
RTL_TOP    := decode_stage
FILELIST   := decode_stage.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data path width
`define XLEN       32
// register index width
`define REG_AW     5
// architectural registers, r0 included
`define NUM_REGS   32

// forwarding slots, index 0 is EXE, then MEM, last is WB
`define NUM_BYPASS 3
// source operands per instruction, rs then rt
`define NUM_SRC    2

`endif

// File: common/isa_pkg.sv
`default_nettype none

`include "id_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // register format
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // jump format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fields_t;

    // one fetched word, three ways to look at it
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // funct selects the op
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // what the EXE alu does with src1/src2
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR,  ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

`include "id_settings.svh"

package pipe_pkg;

    import isa_pkg::*;

    // IF -> ID
    typedef struct packed {
        word_t pc;
        inst_u inst;
    } fetch_bus_t;

    // one forwarding slot from a later stage
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        logic      data_ready;  // low while a load or late mfc0 is in flight
        word_t     data;
    } bypass_t;

    // decoder -> resolver
    typedef struct packed {
        logic      used;
        reg_addr_t addr;
    } src_req_t;

    // resolver -> issue control
    typedef struct packed {
        word_t value;
        logic  hazard;  // producer matched but data not there yet
    } src_res_t;

    // ID -> EXE
    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        logic      src1_is_sa;   // shamt sits in imm_value[10:6]
        logic      src2_is_imm;
        word_t     imm_value;    // already zero or sign extended
        word_t     rs_value;
        word_t     rt_value;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      load_op;
        logic      br_is_imm;    // beq, bne
        logic      br_is_reg;    // jr, target is rs_value
        logic      br_is_jump;   // j, jal
        word_t     br_target;
        logic      ri_ex;        // reserved instruction
    } issue_bus_t;

endpackage

`default_nettype wire

// File: decode_stage.f
+incdir+common
+incdir+tests
common/isa_pkg.sv
common/pipe_pkg.sv
hw/regfile.sv
hw/decode/operand_resolver.sv
hw/decode/inst_decoder.sv
hw/decode/issue_control.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

// File: hw/decode/inst_decoder.sv
`default_nettype none

`include "id_settings.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  fetch_bus_t              held,
    input  logic                    stage_valid,
    output issue_bus_t              ctrl,     // rs_value/rt_value left zero
    output src_req_t [`NUM_SRC-1:0] src_req
);

    inst_u inst;
    word_t seq_pc;       // delay slot pc
    word_t br_offset;
    logic  defined;
    logic  imm_sext;
    logic  rs_read;
    logic  rt_read;
    logic  shamt_zero;

    assign inst       = held.inst;
    assign seq_pc     = held.pc + word_t'(4);
    assign br_offset  = {{(`XLEN-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};
    assign shamt_zero = (inst.r.shamt == '0);

    always_comb begin
        ctrl        = '0;
        ctrl.pc     = held.pc;
        ctrl.alu_op = ALU_ADD;  // default covers addiu, lw, sw, jal link
        defined     = 1'b1;
        imm_sext    = 1'b1;
        rs_read     = 1'b0;
        rt_read     = 1'b0;
        case (inst.r.opcode)
            OP_SPECIAL: begin
                ctrl.dest  = inst.r.rd;
                ctrl.gr_we = 1'b1;
                rs_read    = 1'b1;
                rt_read    = 1'b1;
                defined    = shamt_zero;  // alu ops need sa == 0
                case (inst.r.funct)
                    F_ADDU: ctrl.alu_op = ALU_ADD;
                    F_SUBU: ctrl.alu_op = ALU_SUB;
                    F_SLT:  ctrl.alu_op = ALU_SLT;
                    F_SLTU: ctrl.alu_op = ALU_SLTU;
                    F_AND:  ctrl.alu_op = ALU_AND;
                    F_OR:   ctrl.alu_op = ALU_OR;
                    F_XOR:  ctrl.alu_op = ALU_XOR;
                    F_NOR:  ctrl.alu_op = ALU_NOR;
                    F_SLL, F_SRL, F_SRA: begin
                        ctrl.alu_op = (inst.r.funct == F_SLL) ? ALU_SLL :
                                      (inst.r.funct == F_SRL) ? ALU_SRL : ALU_SRA;
                        ctrl.src1_is_sa = 1'b1;
                        rs_read = 1'b0;                 // rs field must be 0
                        defined = (inst.r.rs == '0);
                    end
                    F_JR: begin
                        ctrl.br_is_reg = 1'b1;
                        ctrl.gr_we     = 1'b0;
                        ctrl.dest      = '0;
                        rt_read        = 1'b0;
                        defined = defined && (inst.r.rt == '0) && (inst.r.rd == '0);
                    end
                    default: defined = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.dest        = inst.i.rt;
                ctrl.gr_we       = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                rs_read          = 1'b1;
                case (inst.r.opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;  // addi behaves as addiu here
                endcase
                if (inst.r.opcode == OP_LUI) begin
                    rs_read = 1'b0;
                    defined = (inst.i.rs == '0);
                end
                // logic ops and lui take the raw 16 bits
                imm_sext = !(inst.r.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
            end
            OP_LW: begin
                ctrl.dest        = inst.i.rt;
                ctrl.gr_we       = 1'b1;
                ctrl.load_op     = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                rs_read          = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_we      = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                rs_read          = 1'b1;
                rt_read          = 1'b1;  // store data
            end
            OP_BEQ, OP_BNE: begin
                ctrl.br_is_imm = 1'b1;
                ctrl.br_target = seq_pc + br_offset;
                rs_read        = 1'b1;
                rt_read        = 1'b1;
            end
            OP_J, OP_JAL: begin
                ctrl.br_is_jump = 1'b1;
                ctrl.br_target  = {seq_pc[`XLEN-1:28], inst.j.index, 2'b00};
                if (inst.r.opcode == OP_JAL) begin
                    ctrl.dest  = reg_addr_t'(`NUM_REGS-1);  // link into r31
                    ctrl.gr_we = 1'b1;
                end
            end
            default: defined = 1'b0;
        endcase
        if (!defined) begin
            // reserved: nothing may write or branch
            ctrl        = '0;
            ctrl.pc     = held.pc;
            ctrl.alu_op = ALU_ADD;
            rs_read     = 1'b0;
            rt_read     = 1'b0;
        end
        ctrl.ri_ex     = !defined;
        ctrl.imm_value = imm_sext ? {{(`XLEN-16){inst.i.imm[15]}}, inst.i.imm}
                                  : {{(`XLEN-16){1'b0}}, inst.i.imm};
    end

    // empty stage asks for nothing, so it never stalls
    assign src_req[0].used = rs_read && stage_valid;
    assign src_req[0].addr = inst.i.rs;
    assign src_req[1].used = rt_read && stage_valid;
    assign src_req[1].addr = inst.i.rt;

endmodule

`default_nettype wire

// File: hw/decode/issue_control.sv
`default_nettype none

`include "id_settings.svh"

module issue_control import pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    fetch_valid,
    input  fetch_bus_t              fetch_bus,
    input  logic                    es_allowin,
    input  issue_bus_t              ctrl,
    input  src_res_t [`NUM_SRC-1:0] src_res,
    output logic                    ds_allowin,
    output logic                    stage_valid,
    output fetch_bus_t              held,
    output logic                    issue_valid,
    output issue_bus_t              issue_bus
);

    logic ready_go;  // all operands in hand

    always_comb begin
        ready_go = 1'b1;
        for (int s = 0; s < `NUM_SRC; s++) begin
            if (src_res[s].hazard) begin
                ready_go = 1'b0;
            end
        end
    end

    // empty, or the held instruction leaves this cycle
    assign ds_allowin  = !stage_valid || (ready_go && es_allowin);
    assign issue_valid = stage_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            stage_valid <= 1'b0;  // flush beats a new accept
        end else if (ds_allowin) begin
            stage_valid <= fetch_valid;
        end
    end

    // payload only, meaningful while stage_valid
    always_ff @(posedge clk) begin
        if (fetch_valid && ds_allowin) begin
            held <= fetch_bus;
        end
    end

    always_comb begin
        issue_bus          = ctrl;
        issue_bus.rs_value = src_res[0].value;
        issue_bus.rt_value = src_res[1].value;
    end

endmodule

`default_nettype wire

// File: hw/decode/operand_resolver.sv
`default_nettype none

`include "id_settings.svh"

module operand_resolver import isa_pkg::*, pipe_pkg::*; (
    input  src_req_t                  req,
    input  word_t                     rf_data,  // async read of req.addr
    input  bypass_t [`NUM_BYPASS-1:0] bypass,   // 0 = EXE, youngest
    output src_res_t                  res
);

    logic fwd_en;

    // r0 never forwards, unused fields never stall
    assign fwd_en = req.used && (req.addr != '0);

    always_comb begin
        res.value  = rf_data;
        res.hazard = 1'b0;
        if (fwd_en) begin
            // walk WB -> EXE so the youngest match is the last one taken
            for (int i = `NUM_BYPASS - 1; i >= 0; i--) begin
                if (bypass[i].valid && (bypass[i].dest == req.addr)) begin
                    res.value  = bypass[i].data;
                    res.hazard = !bypass[i].data_ready;  // load-use, late mfc0
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

`include "id_settings.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    // fetch side
    input  logic                          fetch_valid,
    output logic                          ds_allowin,
    input  fetch_bus_t                    fetch_bus,
    // execute side
    input  logic                          es_allowin,
    output logic                          issue_valid,
    output issue_bus_t                    issue_bus,
    // EXE, MEM, WB forwarding, WB also writes the regfile
    input  bypass_t [`NUM_BYPASS-1:0]     bypass
);

    fetch_bus_t                 held;         // instruction sitting in ID
    logic                       stage_valid;
    issue_bus_t                 ctrl;         // decoded fields, no operands yet
    src_req_t  [`NUM_SRC-1:0]   src_req;
    src_res_t  [`NUM_SRC-1:0]   src_res;
    reg_addr_t [`NUM_SRC-1:0]   rf_raddr;
    word_t     [`NUM_SRC-1:0]   rf_rdata;

    issue_control u_issue (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_bus   (fetch_bus),
        .es_allowin  (es_allowin),
        .ctrl        (ctrl),
        .src_res     (src_res),
        .ds_allowin  (ds_allowin),
        .stage_valid (stage_valid),
        .held        (held),
        .issue_valid (issue_valid),
        .issue_bus   (issue_bus)
    );

    inst_decoder u_dec (
        .held        (held),
        .stage_valid (stage_valid),
        .ctrl        (ctrl),
        .src_req     (src_req)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .wb    (bypass[`NUM_BYPASS-1])  // last slot is WB
    );

    // one resolver per source, 0 = rs, 1 = rt
    for (genvar s = 0; s < `NUM_SRC; s++) begin : g_src
        assign rf_raddr[s] = src_req[s].addr;

        operand_resolver u_res (
            .req     (src_req[s]),
            .rf_data (rf_rdata[s]),
            .bypass  (bypass),
            .res     (src_res[s])
        );
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

`include "id_settings.svh"

module regfile import isa_pkg::*, pipe_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  reg_addr_t [`NUM_SRC-1:0] raddr,
    output word_t     [`NUM_SRC-1:0] rdata,
    input  bypass_t                  wb      // WB slot doubles as write port
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wb.valid && (wb.dest != '0)) begin
            regs[wb.dest] <= wb.data;  // r0 never written
        end
    end

    // async read, same-cycle WB write is covered by the WB bypass
    always_comb begin
        for (int p = 0; p < `NUM_SRC; p++) begin
            rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic bypass_t make_slot(input reg_addr_t dest, input logic ready, input word_t data);
    bypass_t s;
    s.valid      = 1'b1;
    s.dest       = dest;
    s.data_ready = ready;
    s.data       = data;
    return s;
endfunction

function automatic inst_u enc_r(input logic [5:0] funct, input reg_addr_t rs,
                                input reg_addr_t rt, input reg_addr_t rd);
    return inst_u'({6'h00, rs, rt, rd, 5'd0, funct});  // SPECIAL opcode with shamt 0
endfunction

function automatic inst_u enc_i(input logic [5:0] op, input reg_addr_t rs,
                                input reg_addr_t rt, input logic [15:0] imm);
    return inst_u'({op, rs, rt, imm});
endfunction

function automatic inst_u enc_j(input logic [5:0] op, input logic [25:0] index);
    return inst_u'({op, index});
endfunction

// expected bus with operands from the regfile model
function automatic issue_bus_t base_bus(input word_t pc, input inst_u inst);
    issue_bus_t b;
    b           = '0;
    b.pc        = pc;
    b.alu_op    = ALU_ADD;
    b.imm_value = {{(`XLEN-16){inst.i.imm[15]}}, inst.i.imm};  // sign extend by default
    b.rs_value  = model_regs[inst.i.rs];
    b.rt_value  = model_regs[inst.i.rt];
    return b;
endfunction

task automatic check_issue(input string name, input issue_bus_t exp, input issue_bus_t act);
    if (exp !== act) begin
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    end
endtask

// one WB slot write per edge
task automatic write_reg(input reg_addr_t dest, input word_t data);
    @(posedge clk);
    bypass[`NUM_BYPASS-1] <= make_slot(dest, 1'b1, data);
    model_regs[dest] = data;
endtask

// returns right after the accepting edge
task automatic send_inst(input word_t pc, input inst_u inst);
    fetch_bus_t fb;
    int         waited;
    fb.pc  = pc;
    fb.inst = inst;
    waited = 0;
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_bus   <= fb;
    @(negedge clk);
    while (!ds_allowin) begin
        waited++;
        if (waited > max_wait) begin
            $display("fetch side never accepted, ds_allowin stayed low");
            $display("Checks failed");
            $fatal(1, "timeout");
        end
        @(negedge clk);
    end
    @(posedge clk);  // accepted here
    fetch_valid <= 1'b0;
endtask

task automatic wait_issue(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!issue_valid) begin
        waited++;
        if (waited > max_wait) begin
            $display("%s: issue_valid never went high within %0d cycles", name, max_wait);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
        @(negedge clk);
    end
endtask

// send, wait for issue, compare the whole bus
task automatic run_case(input string name, input word_t pc, input inst_u inst,
                        input issue_bus_t exp);
    send_inst(pc, inst);
    wait_issue(name);
    check_issue(name, exp, issue_bus);
endtask

task automatic test_rtype();
    word_t      a;
    word_t      b;
    inst_u      inst;
    issue_bus_t exp;
    a = rand_word();
    b = rand_word();
    write_reg(5'd5, a);
    write_reg(5'd6, b);
    @(posedge clk);
    bypass <= '0;  // values now only in the regfile
    inst      = enc_r(F_ADDU, 5'd5, 5'd6, 5'd7);
    exp       = base_bus(32'h0040_0000, inst);
    exp.dest  = 5'd7;
    exp.gr_we = 1'b1;
    run_case("rtype addu", 32'h0040_0000, inst, exp);
    check_word("rtype rs_value", a, issue_bus.rs_value);
    check_word("rtype rt_value", b, issue_bus.rt_value);
endtask

task automatic test_immediates();
    inst_u      inst;
    issue_bus_t exp;
    inst            = enc_i(OP_ORI, 5'd5, 5'd8, 16'h8001);
    exp             = base_bus(32'h0040_0010, inst);
    exp.alu_op      = ALU_OR;
    exp.src2_is_imm = 1'b1;
    exp.imm_value   = 32'h0000_8001;  // zero extended
    exp.dest        = 5'd8;
    exp.gr_we       = 1'b1;
    run_case("imm ori", 32'h0040_0010, inst, exp);

    inst            = enc_i(OP_ADDIU, 5'd6, 5'd10, 16'hfff0);
    exp             = base_bus(32'h0040_0014, inst);
    exp.src2_is_imm = 1'b1;
    exp.imm_value   = 32'hffff_fff0;  // sign extended
    exp.dest        = 5'd10;
    exp.gr_we       = 1'b1;
    run_case("imm addiu", 32'h0040_0014, inst, exp);

    inst            = enc_i(OP_LUI, 5'd0, 5'd9, 16'habcd);
    exp             = base_bus(32'h0040_0018, inst);
    exp.alu_op      = ALU_LUI;
    exp.src2_is_imm = 1'b1;
    exp.imm_value   = 32'h0000_abcd;
    exp.dest        = 5'd9;
    exp.gr_we       = 1'b1;
    run_case("imm lui", 32'h0040_0018, inst, exp);

    inst            = enc_i(OP_SW, 5'd5, 5'd6, 16'h0010);
    exp             = base_bus(32'h0040_001c, inst);
    exp.src2_is_imm = 1'b1;
    exp.mem_we      = 1'b1;  // store writes no register
    run_case("imm sw", 32'h0040_001c, inst, exp);
endtask

task automatic test_forwarding();
    word_t      a;
    word_t      b;
    word_t      c;
    inst_u      inst;
    issue_bus_t exp;
    a = rand_word();
    b = rand_word();
    c = rand_word();
    @(posedge clk);
    bypass[0] <= make_slot(5'd11, 1'b1, a);  // youngest
    bypass[1] <= make_slot(5'd11, 1'b1, b);
    bypass[2] <= make_slot(5'd11, 1'b1, c);
    model_regs[11] = c;  // WB slot lands in the regfile too
    inst         = enc_r(F_OR, 5'd11, 5'd0, 5'd12);
    exp          = base_bus(32'h0040_0020, inst);
    exp.alu_op   = ALU_OR;
    exp.dest     = 5'd12;
    exp.gr_we    = 1'b1;
    exp.rs_value = a;
    run_case("fwd exe wins", 32'h0040_0020, inst, exp);

    @(posedge clk);
    bypass[0] <= make_slot(5'd0, 1'b1, rand_word());  // r0 producers are never forwarded
    bypass[1] <= make_slot(5'd0, 1'b1, rand_word());
    bypass[2] <= make_slot(5'd0, 1'b1, rand_word());
    inst      = enc_r(F_ADDU, 5'd0, 5'd0, 5'd13);
    exp       = base_bus(32'h0040_0024, inst);
    exp.dest  = 5'd13;
    exp.gr_we = 1'b1;
    run_case("fwd r0", 32'h0040_0024, inst, exp);
    check_word("fwd r0 rs_value", 32'h0, issue_bus.rs_value);
    @(posedge clk);
    bypass <= '0;
endtask

task automatic test_load_use();
    word_t      d;
    inst_u      inst;
    issue_bus_t exp;
    d = rand_word();
    @(posedge clk);
    bypass[0] <= make_slot(5'd14, 1'b0, d);  // load still in EXE
    inst = enc_r(F_ADDU, 5'd14, 5'd5, 5'd15);
    send_inst(32'h0040_0030, inst);
    repeat (3) begin
        @(negedge clk);
        check_flag("load-use issue_valid", 1'b0, issue_valid);
        check_flag("load-use ds_allowin", 1'b0, ds_allowin);
    end
    @(posedge clk);
    bypass[0].data_ready <= 1'b1;
    wait_issue("load-use");
    exp          = base_bus(32'h0040_0030, inst);
    exp.dest     = 5'd15;
    exp.gr_we    = 1'b1;
    exp.rs_value = d;
    check_issue("load-use bus", exp, issue_bus);
    @(posedge clk);
    bypass <= '0;
endtask

task automatic test_backpressure_flush();
    inst_u      inst;
    issue_bus_t exp;
    fetch_bus_t next_fb;
    @(posedge clk);
    es_allowin <= 1'b0;
    inst       = enc_r(F_XOR, 5'd5, 5'd6, 5'd16);
    exp        = base_bus(32'h0040_0040, inst);
    exp.alu_op = ALU_XOR;
    exp.dest   = 5'd16;
    exp.gr_we  = 1'b1;
    run_case("backpressure bus", 32'h0040_0040, inst, exp);
    next_fb.pc   = 32'h0040_0044;
    next_fb.inst = enc_r(F_AND, 5'd6, 5'd5, 5'd17);
    @(posedge clk);
    fetch_valid <= 1'b1;  // next instruction waits at the fetch side
    fetch_bus   <= next_fb;
    repeat (3) begin
        @(negedge clk);
        check_issue("backpressure hold", exp, issue_bus);
        check_flag("backpressure ds_allowin", 1'b0, ds_allowin);
        check_flag("backpressure issue_valid", 1'b1, issue_valid);
    end
    @(posedge clk);
    fetch_valid <= 1'b0;
    flush       <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_flag("flush issue_valid", 1'b0, issue_valid);
    @(posedge clk);
    es_allowin <= 1'b1;
    @(negedge clk);
    check_flag("flush ds_allowin", 1'b1, ds_allowin);
endtask

task automatic test_branch_reserved();
    inst_u      inst;
    issue_bus_t exp;
    inst          = enc_i(OP_BEQ, 5'd5, 5'd6, 16'hfffc);
    exp           = base_bus(32'h0040_0100, inst);
    exp.br_is_imm = 1'b1;
    exp.br_target = 32'h0040_0104 - 32'd16;  // pc + 4 + (-4 * 4)
    run_case("branch beq", 32'h0040_0100, inst, exp);
    check_word("branch beq target", 32'h0040_00f4, issue_bus.br_target);

    inst           = enc_j(OP_J, 26'h012_3456);
    exp            = base_bus(32'hbfc0_0010, inst);
    exp.br_is_jump = 1'b1;
    exp.br_target  = {4'hb, 26'h012_3456, 2'b00};  // region of pc + 4
    run_case("branch j", 32'hbfc0_0010, inst, exp);

    inst      = enc_i(6'h3f, 5'd3, 5'd4, 16'h1234);  // unused opcode
    exp       = base_bus(32'hbfc0_0020, inst);
    exp.ri_ex = 1'b1;
    run_case("reserved opcode", 32'hbfc0_0020, inst, exp);
endtask

`endif

// File: tests/tb_decode_stage.sv
`default_nettype none

`include "id_settings.svh"

module tb_decode_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int max_wait = 20;  // cycles any wait loop may spin

    logic                      clk;
    logic                      reset;
    logic                      flush;
    logic                      fetch_valid;
    logic                      ds_allowin;
    fetch_bus_t                fetch_bus;
    logic                      es_allowin;
    logic                      issue_valid;
    issue_bus_t                issue_bus;
    bypass_t [`NUM_BYPASS-1:0] bypass;  // 0 EXE, 1 MEM, 2 WB

    logic [15:0] lfsr_state;
    word_t       model_regs [`NUM_REGS];  // what the regfile should hold

    decode_stage i_dut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .ds_allowin  (ds_allowin),
        .fetch_bus   (fetch_bus),
        .es_allowin  (es_allowin),
        .issue_valid (issue_valid),
        .issue_bus   (issue_bus),
        .bypass      (bypass)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // period 4

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int b = 0; b < `XLEN; b++) begin
            w = {w[`XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        lfsr_state  = 16'd35297;
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_bus   = '0;
        es_allowin  = 1'b1;
        bypass      = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;  // regfile clears on reset
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_flag("reset issue_valid", 1'b0, issue_valid);  // empty stage
        check_flag("reset ds_allowin", 1'b1, ds_allowin);

        test_rtype();
        test_immediates();
        test_forwarding();
        test_load_use();
        test_backpressure_flush();
        test_branch_reserved();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
